// File: current_loop.f
+incdir+include
source/current_loop_pkg.sv
source/pi_controller.sv
source/pwm_modulator.sv
source/current_loop.sv
dv/current_loop_assertions.sv
dv/current_loop_tb.sv

// File: dv/current_loop_assertions.sv
`timescale 1ns/1ps
`include "current_loop_settings.svh"

module current_loop_assertions (
    input logic                       clk,
    input logic                       reset,
    input logic                       trigger,
    input logic                       ctrl_valid,
    input current_loop_pkg::carrier_t carrier
);

    logic triggered;    // any trigger since reset

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            triggered <= 1'b0;
        else if (trigger)
            triggered <= 1'b1;
    end

    trigger_single: assert property (@(posedge clk) disable iff (reset) trigger |=> !trigger)
        else $error("trigger high for more than one cycle");

    valid_single: assert property (@(posedge clk) disable iff (reset) ctrl_valid |=> !ctrl_valid)
        else $error("ctrl_valid high for more than one cycle");

    valid_after_trigger: assert property (@(posedge clk) disable iff (reset)
        ctrl_valid |-> triggered)
        else $error("ctrl_valid without an earlier trigger");

    carrier_range: assert property (@(posedge clk) disable iff (reset)
        carrier < `CL_PWM_PERIOD)
        else $error("carrier reached the period");

endmodule

// the modulator sees trigger, ctrl_valid and the carrier together
bind pwm_modulator current_loop_assertions u_checks (
    .clk(clk),
    .reset(reset),
    .trigger(trigger),
    .ctrl_valid(ctrl_valid),
    .carrier(carrier)
);

// File: dv/current_loop_tb.sv
`timescale 1ns/1ps
`include "current_loop_settings.svh"

module current_loop_tb;
    import current_loop_pkg::*;

    localparam int CHANNELS = `CL_CHANNELS;
    localparam int DW = `CL_DATA_WIDTH;
    localparam int PERIOD = `CL_PWM_PERIOD;
    localparam longint ACC_LIMIT = longint'(`CL_DATA_LIMIT) << `CL_SCALE;
    localparam int MAX_CYCLES = (25 + 10) * PERIOD;    // 25 periods of tests plus margin

    logic clk;
    logic reset;
    gain_t kp;
    gain_t ki;
    channel_bus_t ref_data;
    logic ref_valid;
    channel_bus_t meas_data;
    logic meas_valid;
    channel_bus_t ctrl_data;
    logic ctrl_valid;
    logic [CHANNELS-1:0] pwm_out;

    channel_bus_t results [$];
    int ref_val [CHANNELS];
    int meas_val [CHANNELS];
    int model_err [CHANNELS];
    longint model_acc [CHANNELS];
    longint expect_out [CHANNELS];
    longint dut_out [CHANNELS];
    int duty_cnt [CHANNELS];
    int cycles = 0;
    int first_draw;

    current_loop uut (
        .clk(clk), .reset(reset), .kp(kp), .ki(ki),
        .ref_data(ref_data), .ref_valid(ref_valid),
        .meas_data(meas_data), .meas_valid(meas_valid),
        .ctrl_data(ctrl_data), .ctrl_valid(ctrl_valid), .pwm_out(pwm_out)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("Timeout after %0d cycles, a controller result never arrived", cycles);
            $display("Simulation FAILED");
            $fatal(1, "timeout");
        end
    end

    // every ctrl_valid pulse is queued for the model
    always @(negedge clk) begin
        if (!reset && ctrl_valid)
            results.push_back(ctrl_data);
    end

    task automatic check_value(input string name, input longint actual, input longint expected);
        if (actual !== expected) begin
            $display("Fail at time %0t: %s = %0d, expected %0d", $time, name, actual, expected);
            $display("Simulation FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic apply_inputs(input int kp_new, input int ki_new,
                                input int r0, input int r1, input int m0, input int m1);
        @(posedge clk);
        #2;
        kp = gain_t'(kp_new);
        ki = gain_t'(ki_new);
        ref_val[0] = r0;
        ref_val[1] = r1;
        meas_val[0] = m0;
        meas_val[1] = m1;
        for (int c = 0; c < CHANNELS; c++) begin
            ref_data[c*DW +: DW] = sample_t'(ref_val[c]);
            meas_data[c*DW +: DW] = sample_t'(meas_val[c]);
        end
        ref_valid = 1'b1;
        meas_valid = 1'b1;
        @(posedge clk);
        #2;
        ref_valid = 1'b0;
        meas_valid = 1'b0;
    endtask

    // velocity form, clamped history, output floor of acc / 2^scale
    task automatic model_step();
        int e;
        longint acc;
        for (int c = 0; c < CHANNELS; c++) begin
            e = ref_val[c] - meas_val[c];
            acc = model_acc[c] + longint'(ki) * e + longint'(kp) * (e - model_err[c]);
            if (acc > ACC_LIMIT)
                acc = ACC_LIMIT;
            else if (acc < -ACC_LIMIT)
                acc = -ACC_LIMIT;
            model_err[c] = e;
            model_acc[c] = acc;
            expect_out[c] = acc >>> `CL_SCALE;
        end
    endtask

    task automatic next_result(input string tag);
        channel_bus_t bus;
        sample_t got;
        while (results.size() == 0)
            @(negedge clk);
        bus = results.pop_front();
        model_step();
        for (int c = 0; c < CHANNELS; c++) begin
            got = bus[c*DW +: DW];
            dut_out[c] = got;
            check_value($sformatf("%s ctrl_data ch%0d", tag, c), got, expect_out[c]);
        end
    endtask

    // one full carrier period starting at the trigger cycle
    task automatic measure_duty();
        for (int c = 0; c < CHANNELS; c++)
            duty_cnt[c] = 0;
        while (uut.trigger !== 1'b1)
            @(negedge clk);
        repeat (PERIOD) begin
            for (int c = 0; c < CHANNELS; c++)
                if (pwm_out[c])
                    duty_cnt[c]++;
            @(negedge clk);
        end
    endtask

    task automatic reset_state();
        repeat (2) begin
            measure_duty();
            for (int c = 0; c < CHANNELS; c++)
                check_value($sformatf("reset pwm_out[%0d] high", c), duty_cnt[c], PERIOD / 2);
        end
        check_value("ctrl_valid pulses without samples", results.size(), 0);
    endtask

    task automatic proportional_step();
        apply_inputs(32767, 0, 100, -60, 0, 0);    // kp of 1.0 clipped to max gain
        repeat (2) next_result("proportional");
    endtask

    task automatic integral_growth();
        apply_inputs(1000, 3000, 50, -30, 0, 0);
        repeat (4) next_result("integral");
    endtask

    task automatic saturation_recovery();
        apply_inputs(32767, 32767, 1000, -1000, 0, 0);
        repeat (3) begin
            next_result("saturate");
            check_value("ctrl_data ch0 at limit", dut_out[0], `CL_DATA_LIMIT);
            check_value("ctrl_data ch1 at limit", dut_out[1], -`CL_DATA_LIMIT);
        end
        apply_inputs(32767, 32767, -1000, 1000, 0, 0);
        next_result("recover");
        check_value("ctrl_data ch0 reversed", dut_out[0], -`CL_DATA_LIMIT);
        check_value("ctrl_data ch1 reversed", dut_out[1], `CL_DATA_LIMIT);
        next_result("recover hold");
    endtask

    task automatic random_duty();
        int r0;
        int r1;
        int m0;
        int m1;
        repeat (3) begin
            r0 = int'($urandom_range(100)) - 50;
            r1 = int'($urandom_range(100)) - 50;
            m0 = int'($urandom_range(100)) - 50;
            m1 = int'($urandom_range(100)) - 50;
            apply_inputs(8000, 500, r0, r1, m0, m1);
            next_result("duty step");
            measure_duty();
            for (int c = 0; c < CHANNELS; c++)
                check_value($sformatf("pwm_out[%0d] high", c), duty_cnt[c],
                            expect_out[c] + PERIOD / 2);
            next_result("duty hold");  // run inside the measured period
            next_result("duty resync");
        end
    endtask

    task automatic channel_split();
        apply_inputs(20000, 1500, 30, -70, 10, 5);
        repeat (2) next_result("channel split");
    endtask

    initial begin
        reset = 1'b1;
        kp = '0;
        ki = '0;
        ref_data = '0;
        ref_valid = 1'b0;
        meas_data = '0;
        meas_valid = 1'b0;
        first_draw = $urandom(32'hea1c);
        for (int c = 0; c < CHANNELS; c++) begin
            model_err[c] = 0;
            model_acc[c] = 0;
        end
        repeat (10) @(posedge clk);
        #2;
        reset = 1'b0;

        reset_state();
        proportional_step();
        integral_growth();
        saturation_recovery();
        random_duty();
        channel_split();

        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: include/current_loop_settings.svh
`ifndef CURRENT_LOOP_SETTINGS_SVH
`define CURRENT_LOOP_SETTINGS_SVH

// sample and controller output width
`define CL_DATA_WIDTH 16

// kp / ki width, signed fixed point
`define CL_GAIN_WIDTH 16

// fractional bits of the gains
`define CL_SCALE 16

// number of time-shared channels (d and q)
`define CL_CHANNELS 2

// output magnitude limit, integer units
`define CL_DATA_LIMIT 100

// carrier length in clock cycles
// keep CL_DATA_LIMIT below half of this so duty never clips
`define CL_PWM_PERIOD 256

`endif

// File: source/current_loop.sv
`timescale 1ns/1ps
`include "current_loop_settings.svh"

module current_loop (
    input  logic                          clk,
    input  logic                          reset,
    input  current_loop_pkg::gain_t       kp,
    input  current_loop_pkg::gain_t       ki,
    input  current_loop_pkg::channel_bus_t ref_data,
    input  logic                          ref_valid,
    input  current_loop_pkg::channel_bus_t meas_data,
    input  logic                          meas_valid,
    output current_loop_pkg::channel_bus_t ctrl_data,
    output logic                          ctrl_valid,
    output logic [`CL_CHANNELS-1:0]       pwm_out
);

    logic trigger;  // one pulse per carrier wrap

    pi_controller #(
        .CHANNELS(`CL_CHANNELS)
    ) u_pi (
        .clk(clk),
        .reset(reset),
        .trigger(trigger),
        .kp(kp),
        .ki(ki),
        .ref_data(ref_data),
        .meas_data(meas_data),
        .ref_valid(ref_valid),
        .meas_valid(meas_valid),
        .ctrl_data(ctrl_data),
        .ctrl_valid(ctrl_valid)
    );

    // new duty lands one carrier period after the trigger
    pwm_modulator u_pwm (
        .clk(clk),
        .reset(reset),
        .ctrl_data(ctrl_data),
        .ctrl_valid(ctrl_valid),
        .trigger(trigger),
        .pwm_out(pwm_out)
    );

endmodule

// File: source/current_loop_pkg.sv
`include "current_loop_settings.svh"

package current_loop_pkg;

    // one sample or one controller output
    typedef logic signed [`CL_DATA_WIDTH-1:0] sample_t;

    typedef logic signed [`CL_GAIN_WIDTH-1:0] gain_t;

    // product and accumulator width
    typedef logic signed [`CL_GAIN_WIDTH+`CL_DATA_WIDTH-1:0] acc_t;

    // channel 0 in the lowest slice
    typedef logic [`CL_CHANNELS*`CL_DATA_WIDTH-1:0] channel_bus_t;

    // one extra bit over the period
    typedef logic [$clog2(`CL_PWM_PERIOD):0] carrier_t;

    // per-channel controller phases
    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        INTEG,
        PROP,
        SUM,
        STORE
    } pi_phase_t;

endpackage

// File: source/pi_controller.sv
`timescale 1ns/1ps
`include "current_loop_settings.svh"

module pi_controller #(
    parameter int CHANNELS = `CL_CHANNELS
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          trigger,
    input  current_loop_pkg::gain_t       kp,
    input  current_loop_pkg::gain_t       ki,
    input  current_loop_pkg::channel_bus_t ref_data,
    input  current_loop_pkg::channel_bus_t meas_data,
    input  logic                          ref_valid,
    input  logic                          meas_valid,
    output current_loop_pkg::channel_bus_t ctrl_data,
    output logic                          ctrl_valid
);
    import current_loop_pkg::*;

    localparam int SCALE = `CL_SCALE;
    localparam int DATA_WIDTH = $bits(sample_t);
    localparam int CHAN_W = (CHANNELS > 1) ? $clog2(CHANNELS) : 1;

    // clamp bounds in accumulator scale
    localparam acc_t ACC_MAX = acc_t'(`CL_DATA_LIMIT) <<< SCALE;
    localparam acc_t ACC_MIN = -ACC_MAX;

    // latched inputs
    sample_t ref_q [CHANNELS];
    sample_t meas_q [CHANNELS];
    logic ref_seen;
    logic meas_seen;

    // sequencer
    pi_phase_t phase;
    logic [CHAN_W-1:0] chan;
    logic last_chan;

    // datapath
    sample_t err;
    sample_t err_diff;
    sample_t mul_a;
    gain_t mul_b;
    acc_t product;
    acc_t acc;
    acc_t acc_sat;

    // per-channel history
    sample_t err_hist [CHANNELS];
    acc_t u_hist [CHANNELS];

    assign last_chan = (chan == CHAN_W'(CHANNELS - 1));

    always_ff @(posedge clk) begin
        if (ref_valid) begin
            for (int i = 0; i < CHANNELS; i++) begin
                ref_q[i] <= ref_data[i*DATA_WIDTH +: DATA_WIDTH];
            end
        end
        if (meas_valid) begin
            for (int i = 0; i < CHANNELS; i++) begin
                meas_q[i] <= meas_data[i*DATA_WIDTH +: DATA_WIDTH];
            end
        end
    end

    // sticky arrival flags, cleared only by reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ref_seen <= 1'b0;
            meas_seen <= 1'b0;
        end else begin
            if (ref_valid)
                ref_seen <= 1'b1;
            if (meas_valid)
                meas_seen <= 1'b1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase <= IDLE;
            chan <= '0;
            ctrl_valid <= 1'b0;
        end else begin
            ctrl_valid <= 1'b0;
            case (phase)
                IDLE: begin
                    // triggers before both vectors arrive are dropped
                    if (trigger && ref_seen && meas_seen) begin
                        phase <= LOAD;
                        chan <= '0;
                    end
                end
                LOAD:  phase <= INTEG;
                INTEG: phase <= PROP;
                PROP:  phase <= SUM;
                SUM:   phase <= STORE;
                STORE: begin
                    if (last_chan) begin
                        phase <= IDLE;
                        chan <= '0;
                        ctrl_valid <= 1'b1;
                    end else begin
                        phase <= LOAD;
                        chan <= chan + 1'b1;
                    end
                end
                default: phase <= IDLE;
            endcase
        end
    end

    // single multiplier shared by both terms
    assign product = mul_a * mul_b;

    always_comb begin
        if (acc > ACC_MAX)
            acc_sat = ACC_MAX;
        else if (acc < ACC_MIN)
            acc_sat = ACC_MIN;
        else
            acc_sat = acc;
    end

    always_ff @(posedge clk) begin
        case (phase)
            LOAD: err <= ref_q[chan] - meas_q[chan];
            INTEG: begin
                mul_a <= err;
                mul_b <= ki;
                err_diff <= err - err_hist[chan];
                acc <= u_hist[chan];    // previous clamped output
            end
            PROP: begin
                mul_a <= err_diff;
                mul_b <= kp;
                acc <= acc + product;   // ki * e
            end
            SUM: acc <= acc + product;  // kp * (e - e_prev)
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < CHANNELS; i++) begin
                err_hist[i] <= '0;
                u_hist[i] <= '0;
            end
            ctrl_data <= '0;
        end else begin
            if (phase == INTEG)
                err_hist[chan] <= err;
            if (phase == STORE) begin
                u_hist[chan] <= acc_sat;
                ctrl_data[chan*DATA_WIDTH +: DATA_WIDTH] <= acc_sat[SCALE +: DATA_WIDTH];
            end
        end
    end

endmodule

// File: source/pwm_modulator.sv
`timescale 1ns/1ps
`include "current_loop_settings.svh"

module pwm_modulator (
    input  logic                          clk,
    input  logic                          reset,
    input  current_loop_pkg::channel_bus_t ctrl_data,
    input  logic                          ctrl_valid,
    output logic                          trigger,
    output logic [`CL_CHANNELS-1:0]       pwm_out
);
    import current_loop_pkg::*;

    localparam int CHANNELS = `CL_CHANNELS;
    localparam int PERIOD = `CL_PWM_PERIOD;
    localparam int DATA_WIDTH = $bits(sample_t);
    localparam carrier_t HALF = carrier_t'(PERIOD / 2);
    localparam carrier_t LAST = carrier_t'(PERIOD - 1);

    carrier_t carrier;
    carrier_t carrier_nxt;
    logic wrap;

    carrier_t new_cmp [CHANNELS];
    carrier_t pending [CHANNELS];
    carrier_t active [CHANNELS];
    carrier_t active_nxt [CHANNELS];

    assign wrap = (carrier == LAST);
    assign carrier_nxt = wrap ? '0 : carrier + 1'b1;

    // controller output centred on half period
    always_comb begin
        for (int i = 0; i < CHANNELS; i++) begin
            new_cmp[i] = carrier_t'(sample_t'(ctrl_data[i*DATA_WIDTH +: DATA_WIDTH])
                                    + sample_t'(HALF));
        end
    end

    always_comb begin
        for (int i = 0; i < CHANNELS; i++) begin
            active_nxt[i] = wrap ? pending[i] : active[i];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            carrier <= '0;
            trigger <= 1'b0;
        end else begin
            carrier <= carrier_nxt;
            trigger <= wrap;    // high while carrier is zero
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < CHANNELS; i++) begin
                pending[i] <= HALF;
                active[i] <= HALF;
            end
        end else begin
            for (int i = 0; i < CHANNELS; i++) begin
                if (ctrl_valid)
                    pending[i] <= new_cmp[i];
                active[i] <= active_nxt[i];
            end
        end
    end

    // compared one step ahead so the output lines up with carrier
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pwm_out <= '0;
        end else begin
            for (int i = 0; i < CHANNELS; i++) begin
                pwm_out[i] <= (carrier_nxt < active_nxt[i]);
            end
        end
    end

endmodule
